/* source/wb_params.svh */
// Writeback stage parameters
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// Result and operand width
`define XLEN 32

// Instruction ID width
`define ID_W 4

// One quotient bit per iteration
`define DIV_STEPS `XLEN

// Units sharing writeback port 1 (divider, multiplier)
`define G1_UNITS 2

`endif

/* source/wb_types_pkg.sv */
// Writeback shared types
`include "wb_params.svh"

package wb_types_pkg;

    // Payload and tag vectors
    typedef logic [`XLEN-1:0] data_t;
    typedef logic [`ID_W-1:0] id_t;

    // ALU operation select
    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    // Must hold DIV_STEPS itself, not just DIV_STEPS-1
    typedef logic [$clog2(`DIV_STEPS+1)-1:0] step_t;

    // Divider sequencing
    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_HOLD} div_state_t;

endpackage

/* source/alu_unit.sv */
// Single-cycle ALU
`timescale 1ns/1ps

module alu_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  wb_types_pkg::alu_op_t op,
    input  wb_types_pkg::id_t    issue_id,
    input  wb_types_pkg::data_t  a,
    input  wb_types_pkg::data_t  b,
    output logic                 done,
    output wb_types_pkg::id_t    id,
    output wb_types_pkg::data_t  rd
);
    import wb_types_pkg::*;

    data_t result;

    // Operation select
    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = '0;
        endcase
    end

    // Group 0 never stalls, so done lasts exactly one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= issue;
        end
    end

    always_ff @(posedge clk) begin
        id <= issue_id;
        rd <= result;
    end

endmodule

/* source/mul_unit.sv */
// Two-stage multiplier
`timescale 1ns/1ps

module mul_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  wb_types_pkg::id_t   issue_id,
    input  wb_types_pkg::data_t a,
    input  wb_types_pkg::data_t b,
    input  logic                ack,
    output logic                ready,
    output logic                done,
    output wb_types_pkg::id_t   id,
    output wb_types_pkg::data_t rd
);
    import wb_types_pkg::*;

    // Stage 1 holds operands, stage 2 holds the product
    logic  s1_valid;
    id_t   s1_id;
    data_t s1_a;
    data_t s1_b;
    logic  s2_valid;
    logic  advance;

    // Stage 2 drains when empty or acknowledged
    // Stage 1 moves with it, so one enable covers both
    assign advance = !s2_valid || ack;
    assign ready   = advance;

    //////////////////////////////
    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    //////////////////////////////
    // Payload
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_id <= issue_id;
            s1_a  <= a;
            s1_b  <= b;
            id    <= s1_id;
            // Low word only
            rd    <= s1_a * s1_b;
        end
    end

    assign done = s2_valid;

endmodule

/* source/div_control.sv */
// Divider control FSM
`timescale 1ns/1ps

module div_control (
    input  logic clk,
    input  logic rst,
    input  logic issue,
    input  logic last,
    input  logic ack,
    output logic load,
    output logic step,
    output logic ready,
    output logic done
);
    import wb_types_pkg::*;

    div_state_t state;
    div_state_t next_state;

    //////////////////////////////
    // Next state
    always_comb begin
        next_state = state;
        case (state)
            DIV_IDLE: begin
                if (issue) begin
                    next_state = DIV_RUN;
                end
            end
            // Last step is taken on the way out
            DIV_RUN: begin
                if (last) begin
                    next_state = DIV_HOLD;
                end
            end
            // Result held until writeback takes it
            DIV_HOLD: begin
                if (ack) begin
                    next_state = DIV_IDLE;
                end
            end
            default: next_state = DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // Outputs
    assign ready = (state == DIV_IDLE);
    assign load  = issue && ready;
    assign step  = (state == DIV_RUN);
    assign done  = (state == DIV_HOLD);

endmodule

/* source/div_counter.sv */
// Divider iteration counter
`timescale 1ns/1ps
`include "wb_params.svh"

module div_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic step,
    output logic last
);
    import wb_types_pkg::*;

    step_t remaining;

    // Reload wins over step
    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= step_t'(`DIV_STEPS);
        end else if (step && remaining != '0) begin
            remaining <= remaining - step_t'(1);
        end
    end

    // Flag the final iteration
    assign last = (remaining == step_t'(1));

endmodule

/* source/div_datapath.sv */
// Restoring divider datapath
`timescale 1ns/1ps

module div_datapath (
    input  logic                clk,
    input  logic                load,
    input  logic                step,
    input  wb_types_pkg::id_t   issue_id,
    input  logic                rem_sel,
    input  wb_types_pkg::data_t a,
    input  wb_types_pkg::data_t b,
    output wb_types_pkg::id_t   id,
    output wb_types_pkg::data_t rd
);
    import wb_types_pkg::*;

    // Partial remainder, dividend shifting into quotient, divisor
    data_t rem_r;
    data_t quo_r;
    data_t dvs_r;
    logic  sel_r;

    // One bit wider so the borrow shows up in the top bit
    logic [$bits(data_t):0] shifted;
    logic [$bits(data_t):0] trial;

    //////////////////////////////
    // Trial subtract
    assign shifted = {rem_r, quo_r[$bits(data_t)-1]};
    assign trial   = shifted - {1'b0, dvs_r};

    always_ff @(posedge clk) begin
        if (load) begin
            rem_r <= '0;
            quo_r <= a;
            dvs_r <= b;
            sel_r <= rem_sel;
            id    <= issue_id;
        end else if (step) begin
            if (!trial[$bits(data_t)]) begin
                // Fits, keep the difference
                rem_r <= trial[$bits(data_t)-1:0];
                quo_r <= {quo_r[$bits(data_t)-2:0], 1'b1};
            end else begin
                // Restore
                rem_r <= shifted[$bits(data_t)-1:0];
                quo_r <= {quo_r[$bits(data_t)-2:0], 1'b0};
            end
        end
    end

    //////////////////////////////
    // Result select
    // Zero divisor gives all-ones quotient, remainder = dividend
    assign rd = sel_r ? rem_r : quo_r;

endmodule

/* source/writeback.sv */
// Result writeback select
`timescale 1ns/1ps
`include "wb_params.svh"

module writeback (
    input  logic                clk,
    input  logic                rst,
    input  logic                alu_done,
    input  wb_types_pkg::id_t   alu_id,
    input  wb_types_pkg::data_t alu_rd,
    input  logic                div_done,
    input  wb_types_pkg::id_t   div_id,
    input  wb_types_pkg::data_t div_rd,
    output logic                div_ack,
    input  logic                mul_done,
    input  wb_types_pkg::id_t   mul_id,
    input  wb_types_pkg::data_t mul_rd,
    output logic                mul_ack,
    output logic                wb0_valid,
    output wb_types_pkg::id_t   wb0_id,
    output wb_types_pkg::data_t wb0_data,
    output logic                wb1_valid,
    output wb_types_pkg::id_t   wb1_id,
    output wb_types_pkg::data_t wb1_data,
    output logic                snoop_valid,
    output wb_types_pkg::id_t   snoop_id,
    output wb_types_pkg::data_t snoop_data
);
    import wb_types_pkg::*;

    localparam int SEL_W = (`G1_UNITS > 1) ? $clog2(`G1_UNITS) : 1;

    // Group 1 in priority order, divider first
    logic [`G1_UNITS-1:0] g1_done;
    logic [`G1_UNITS-1:0] g1_ack;
    id_t                  g1_id [`G1_UNITS];
    data_t                g1_rd [`G1_UNITS];
    logic [SEL_W-1:0]     g1_sel;

    assign g1_done = {mul_done, div_done};
    assign g1_id   = '{div_id, mul_id};
    assign g1_rd   = '{div_rd, mul_rd};
    assign div_ack = g1_ack[0];
    assign mul_ack = g1_ack[1];

    //////////////////////////////
    // Group 0, single unit
    assign wb0_valid = alu_done;
    assign wb0_id    = alu_id;
    assign wb0_data  = alu_rd;

    //////////////////////////////
    // Group 1 select
    // Scan down so the lowest index ends up selected
    always_comb begin
        g1_sel = '0;
        for (int i = `G1_UNITS - 1; i >= 0; i--) begin
            if (g1_done[i]) begin
                g1_sel = SEL_W'(i);
            end
        end
    end

    assign wb1_valid = |g1_done;
    assign wb1_id    = g1_id[g1_sel];
    assign wb1_data  = g1_rd[g1_sel];

    // Ack only the winner
    always_comb begin
        g1_ack         = '0;
        g1_ack[g1_sel] = wb1_valid;
    end

    //////////////////////////////
    // Snoop copy for store forwarding
    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_valid <= 1'b0;
        end else begin
            snoop_valid <= wb1_valid;
        end
    end

    always_ff @(posedge clk) begin
        snoop_id   <= wb1_id;
        snoop_data <= wb1_data;
    end

endmodule

/* source/wb_top.sv */
// Execution units and writeback
`timescale 1ns/1ps

module wb_top (
    input  logic                  clk,
    input  logic                  rst,
    // ALU issue
    input  logic                  alu_issue,
    input  wb_types_pkg::alu_op_t alu_op,
    input  wb_types_pkg::id_t     alu_id,
    input  wb_types_pkg::data_t   alu_a,
    input  wb_types_pkg::data_t   alu_b,
    // Multiplier issue
    input  logic                  mul_issue,
    input  wb_types_pkg::id_t     mul_id,
    input  wb_types_pkg::data_t   mul_a,
    input  wb_types_pkg::data_t   mul_b,
    output logic                  mul_ready,
    // Divider issue
    input  logic                  div_issue,
    input  logic                  div_rem,
    input  wb_types_pkg::id_t     div_id,
    input  wb_types_pkg::data_t   div_a,
    input  wb_types_pkg::data_t   div_b,
    output logic                  div_ready,
    // Writeback ports
    output logic                  wb0_valid,
    output wb_types_pkg::id_t     wb0_id,
    output wb_types_pkg::data_t   wb0_data,
    output logic                  wb1_valid,
    output wb_types_pkg::id_t     wb1_id,
    output wb_types_pkg::data_t   wb1_data,
    output logic                  snoop_valid,
    output wb_types_pkg::id_t     snoop_id,
    output wb_types_pkg::data_t   snoop_data
);
    import wb_types_pkg::*;

    // Unit results toward writeback
    logic  alu_done;
    id_t   alu_res_id;
    data_t alu_rd;
    logic  mul_done;
    logic  mul_ack;
    id_t   mul_res_id;
    data_t mul_rd;
    logic  div_done;
    logic  div_ack;
    id_t   div_res_id;
    data_t div_rd;

    // Divider internals
    logic div_load;
    logic div_step;
    logic div_last;

    //////////////////////////////
    // Group 0
    alu_unit u_alu (
        .clk(clk), .rst(rst), .issue(alu_issue), .op(alu_op), .issue_id(alu_id),
        .a(alu_a), .b(alu_b), .done(alu_done), .id(alu_res_id), .rd(alu_rd)
    );

    //////////////////////////////
    // Group 1
    mul_unit u_mul (
        .clk(clk), .rst(rst), .issue(mul_issue), .issue_id(mul_id), .a(mul_a), .b(mul_b),
        .ack(mul_ack), .ready(mul_ready), .done(mul_done), .id(mul_res_id), .rd(mul_rd)
    );

    div_control u_div_ctrl (
        .clk(clk), .rst(rst), .issue(div_issue), .last(div_last), .ack(div_ack),
        .load(div_load), .step(div_step), .ready(div_ready), .done(div_done)
    );

    div_counter u_div_cnt (
        .clk(clk), .rst(rst), .load(div_load), .step(div_step), .last(div_last)
    );

    div_datapath u_div_dp (
        .clk(clk), .load(div_load), .step(div_step), .issue_id(div_id), .rem_sel(div_rem),
        .a(div_a), .b(div_b), .id(div_res_id), .rd(div_rd)
    );

    //////////////////////////////
    // Writeback select
    writeback u_wb (
        .clk(clk), .rst(rst),
        .alu_done(alu_done), .alu_id(alu_res_id), .alu_rd(alu_rd),
        .div_done(div_done), .div_id(div_res_id), .div_rd(div_rd), .div_ack(div_ack),
        .mul_done(mul_done), .mul_id(mul_res_id), .mul_rd(mul_rd), .mul_ack(mul_ack),
        .wb0_valid(wb0_valid), .wb0_id(wb0_id), .wb0_data(wb0_data),
        .wb1_valid(wb1_valid), .wb1_id(wb1_id), .wb1_data(wb1_data),
        .snoop_valid(snoop_valid), .snoop_id(snoop_id), .snoop_data(snoop_data)
    );

endmodule

/* test/wb_checker.sv */
// Writeback port checker
`timescale 1ns/1ps
`include "wb_params.svh"

module wb_checker (
    input  logic                                 clk,
    input  logic                                 rst,
    // Issue strobes tell which unit owns each ID
    input  logic                                 alu_issue,
    input  wb_types_pkg::id_t                    alu_id,
    input  logic                                 mul_issue,
    input  logic                                 mul_ready,
    input  wb_types_pkg::id_t                    mul_id,
    input  logic                                 div_issue,
    input  logic                                 div_ready,
    input  wb_types_pkg::id_t                    div_id,
    // Writeback side
    input  logic                                 wb0_valid,
    input  wb_types_pkg::id_t                    wb0_id,
    input  wb_types_pkg::data_t                  wb0_data,
    input  logic                                 wb1_valid,
    input  wb_types_pkg::id_t                    wb1_id,
    input  wb_types_pkg::data_t                  wb1_data,
    input  logic                                 snoop_valid,
    input  wb_types_pkg::id_t                    snoop_id,
    input  wb_types_pkg::data_t                  snoop_data,
    // Expected data by ID and test framing
    input  wb_types_pkg::data_t [(1<<`ID_W)-1:0] exp_data,
    input  logic                                 test_end,
    input  int                                   test_num,
    output int                                   outstanding,
    output int                                   err_count,
    output int                                   test_count,
    output int                                   fail_count
);
    import wb_types_pkg::*;

    localparam int NUM_IDS   = 1 << `ID_W;
    localparam int UNIT_NONE = -1;
    localparam int UNIT_ALU  = 0;
    localparam int UNIT_MUL  = 1;
    localparam int UNIT_DIV  = 2;

    // Per-ID bookkeeping for the running test
    int    issued_unit [NUM_IDS];
    int    issue_cycle [NUM_IDS];
    int    due_cycle [NUM_IDS];
    bit    written [NUM_IDS];
    int    cycle = 0;
    int    errors = 0;
    int    base_err = 0;
    int    n_issued = 0;
    int    n_results = 0;
    int    n_tests = 0;
    int    n_failed = 0;
    bit    rst_seen = 1'b0;
    bit    reset_done = 1'b0;
    bit    prev_ok = 1'b0;
    bit    mul_stall;
    // Group 1 port as seen one edge earlier
    logic  prev_valid;
    id_t   prev_id;
    data_t prev_data;

    assign outstanding = n_issued - n_results;
    assign err_count   = errors;
    assign test_count  = n_tests;
    assign fail_count  = n_failed;

    task automatic clear_tables();
        for (int i = 0; i < NUM_IDS; i++) begin
            issued_unit[i] = UNIT_NONE;
            written[i]     = 1'b0;
        end
        n_issued  = 0;
        n_results = 0;
    endtask

    task automatic expect_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Mismatch %s: expected %h, got %h", name, want, got);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        expect_bit("wb0_valid", wb0_valid, 1'b0);
        expect_bit("wb1_valid", wb1_valid, 1'b0);
        expect_bit("snoop_valid", snoop_valid, 1'b0);
        expect_bit("mul_ready", mul_ready, 1'b1);
        expect_bit("div_ready", div_ready, 1'b1);
    endtask

    task automatic note_issue(input id_t iid, input int unit);
        issued_unit[iid] = unit;
        issue_cycle[iid] = cycle;
        // Latency of each unit when nothing holds it
        case (unit)
            UNIT_ALU: due_cycle[iid] = cycle + 1;
            UNIT_MUL: due_cycle[iid] = cycle + 2;
            default:  due_cycle[iid] = cycle + `DIV_STEPS + 1;
        endcase
        n_issued++;
    endtask

    // Divider still owns an unfinished operation
    function automatic bit div_busy();
        for (int i = 0; i < NUM_IDS; i++) begin
            if (issued_unit[i] == UNIT_DIV && !written[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Multiplier result is done while the divider wins wb1
    function automatic bit mul_held();
        if (!wb1_valid || issued_unit[wb1_id] != UNIT_DIV) begin
            return 1'b0;
        end
        for (int i = 0; i < NUM_IDS; i++) begin
            if (issued_unit[i] == UNIT_MUL && !written[i] && due_cycle[i] <= cycle) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Both multiplier stages hold for one cycle
    task automatic delay_mul_results();
        for (int i = 0; i < NUM_IDS; i++) begin
            if (issued_unit[i] == UNIT_MUL && !written[i]) begin
                due_cycle[i]++;
            end
        end
    endtask

    task automatic check_result(input int port, input id_t rid, input data_t rdata);
        if (issued_unit[rid] == UNIT_NONE) begin
            $display("ID %h was written back on wb%0d but never issued", rid, port);
            errors++;
        end else if (written[rid]) begin
            $display("ID %h was written back a second time on wb%0d", rid, port);
            errors++;
        end else begin
            written[rid] = 1'b1;
            n_results++;
            if ((issued_unit[rid] == UNIT_ALU) != (port == 0)) begin
                $display("ID %h came out on wb%0d, the wrong port for its unit", rid, port);
                errors++;
            end
            if (rdata !== exp_data[rid]) begin
                $display("Mismatch wb%0d_data for ID %h: expected %h, got %h",
                         port, rid, exp_data[rid], rdata);
                errors++;
            end
            // Multiplier latency grows by one for each held cycle
            if (cycle != due_cycle[rid]) begin
                $display("Result for ID %h arrived %0d cycles after issue instead of %0d",
                         rid, cycle - issue_cycle[rid], due_cycle[rid] - issue_cycle[rid]);
                errors++;
            end
        end
    endtask

    task automatic finish_test();
        n_tests++;
        if (errors != base_err) begin
            n_failed++;
            $display("Test %0d failed with %0d errors", test_num, errors - base_err);
        end else begin
            $display("Test %0d passed, %0d results checked", test_num, n_results);
        end
        base_err = errors;
        clear_tables();
    endtask

    //////////////////////////////
    // Sampling on rising edges
    always @(posedge clk) begin
        if (rst) begin
            clear_tables();
            // First edge still shows power-up values
            if (rst_seen) begin
                check_reset_state();
            end
            rst_seen = 1'b1;
            prev_ok  = 1'b0;
        end else begin
            if (!reset_done) begin
                check_reset_state();
                finish_test();
                reset_done = 1'b1;
            end
            // Snoop lags wb1 by one edge
            if (prev_ok) begin
                expect_bit("snoop_valid", snoop_valid, prev_valid);
                if (prev_valid && snoop_id !== prev_id) begin
                    $display("Mismatch snoop_id: expected %h, got %h", prev_id, snoop_id);
                    errors++;
                end
                if (prev_valid && snoop_data !== prev_data) begin
                    $display("Mismatch snoop_data: expected %h, got %h", prev_data, snoop_data);
                    errors++;
                end
            end
            // Ready levels before this edge's results are booked
            mul_stall = mul_held();
            expect_bit("mul_ready", mul_ready, !mul_stall);
            expect_bit("div_ready", div_ready, !div_busy());
            if (mul_stall) begin
                delay_mul_results();
            end
            if (wb0_valid) begin
                check_result(0, wb0_id, wb0_data);
            end
            if (wb1_valid) begin
                check_result(1, wb1_id, wb1_data);
            end
            if (alu_issue) begin
                note_issue(alu_id, UNIT_ALU);
            end
            if (mul_issue && mul_ready) begin
                note_issue(mul_id, UNIT_MUL);
            end
            if (div_issue && div_ready) begin
                note_issue(div_id, UNIT_DIV);
            end
            if (test_end) begin
                finish_test();
            end
            prev_ok = 1'b1;
        end
        prev_valid = wb1_valid;
        prev_id    = wb1_id;
        prev_data  = wb1_data;
        cycle++;
    end

endmodule

/* test/wb_tb.sv */
// Writeback stage testbench
`timescale 1ns/1ps
`include "wb_params.svh"

// Free-running clock, 100 ns period
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end
endmodule

module wb_tb;
    import wb_types_pkg::*;

    localparam int NUM_IDS    = 1 << `ID_W;
    localparam int RST_CYCLES = 16;
    // Unit codes of the stimulus file
    localparam int UNIT_ALU  = 0;
    localparam int UNIT_MUL  = 1;
    localparam int UNIT_DIV  = 2;
    localparam int UNIT_WAIT = 8;
    localparam int UNIT_END  = 9;

    logic    clk;
    logic    rst;
    logic    alu_issue;
    alu_op_t alu_op;
    id_t     alu_id;
    data_t   alu_a;
    data_t   alu_b;
    logic    mul_issue;
    id_t     mul_id;
    data_t   mul_a;
    data_t   mul_b;
    logic    mul_ready;
    logic    div_issue;
    logic    div_rem;
    id_t     div_id;
    data_t   div_a;
    data_t   div_b;
    logic    div_ready;
    logic    wb0_valid;
    id_t     wb0_id;
    data_t   wb0_data;
    logic    wb1_valid;
    id_t     wb1_id;
    data_t   wb1_data;
    logic    snoop_valid;
    id_t     snoop_id;
    data_t   snoop_data;

    // Expected result per ID, read by the checker
    data_t [NUM_IDS-1:0] exp_data;
    logic                test_end;
    int                  test_num;
    int                  outstanding;
    int                  err_count;
    int                  test_count;
    int                  fail_count;

    // Stimulus file contents, one entry per line
    int    st_unit [$];
    int    st_op [$];
    id_t   st_id [$];
    data_t st_a [$];
    data_t st_b [$];
    data_t st_exp [$];
    int    tests_expected;
    bit    load_failed;
    bit    loaded;
    bit    skip_gap;
    logic [31:0] seed;

    tb_clock u_clock (.clk(clk));

    wb_top uut (.*);

    wb_checker u_check (.*);

    //////////////////////////////
    // Helpers
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit unit_ready(input int unit);
        if (unit == UNIT_MUL) begin
            return mul_ready;
        end
        if (unit == UNIT_DIV) begin
            return div_ready;
        end
        // ALU never stalls
        return 1'b1;
    endfunction

    task automatic read_stim();
        int    fd;
        int    n;
        string line;
        int    f_unit;
        int    f_op;
        int    f_id;
        data_t f_a;
        data_t f_b;
        data_t f_exp;
        fd = $fopen("test/wb_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/wb_stim.txt");
            load_failed = 1'b1;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h", f_unit, f_op, f_id, f_a, f_b, f_exp);
                if (line.len() > 0 && line[0] == "#") begin
                    continue;
                end
                if (n == 6) begin
                    st_unit.push_back(f_unit);
                    st_op.push_back(f_op);
                    st_id.push_back(id_t'(f_id));
                    st_a.push_back(f_a);
                    st_b.push_back(f_b);
                    st_exp.push_back(f_exp);
                    if (f_unit == UNIT_END) begin
                        tests_expected++;
                    end
                end else if (n > 0) begin
                    $display("Stimulus line is malformed: %s", line);
                    load_failed = 1'b1;
                end
            end
            $fclose(fd);
        end
        if (st_unit.size() == 0) begin
            $display("The stimulus file holds no operations");
            load_failed = 1'b1;
        end
        loaded = 1'b1;
    endtask

    // Entered on a falling edge with all strobes low
    task automatic issue_op(input int i);
        while (!unit_ready(st_unit[i])) begin
            @(negedge clk);
        end
        exp_data[st_id[i]] = st_exp[i];
        case (st_unit[i])
            UNIT_ALU: begin
                alu_issue = 1'b1;
                alu_op    = alu_op_t'(st_op[i]);
                alu_id    = st_id[i];
                alu_a     = st_a[i];
                alu_b     = st_b[i];
            end
            UNIT_MUL: begin
                mul_issue = 1'b1;
                mul_id    = st_id[i];
                mul_a     = st_a[i];
                mul_b     = st_b[i];
            end
            default: begin
                div_issue = 1'b1;
                div_rem   = (st_op[i] != 0);
                div_id    = st_id[i];
                div_a     = st_a[i];
                div_b     = st_b[i];
            end
        endcase
        @(negedge clk);
        alu_issue = 1'b0;
        mul_issue = 1'b0;
        div_issue = 1'b0;
    endtask

    // Drain, then let the checker close the test
    task automatic end_test();
        while (outstanding != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
        test_num++;
    endtask

    task automatic run_line(input int i);
        int gap;
        case (st_unit[i])
            UNIT_ALU, UNIT_MUL, UNIT_DIV: begin
                // A preceding wait line fixes the spacing instead
                if (!skip_gap) begin
                    seed = next_random(seed);
                    gap  = int'(seed[17:16]);
                    repeat (gap) @(negedge clk);
                end
                issue_op(i);
                skip_gap = 1'b0;
            end
            UNIT_WAIT: begin
                repeat (int'(st_a[i])) @(negedge clk);
                skip_gap = 1'b1;
            end
            UNIT_END: begin
                end_test();
            end
            default: begin
                $display("Stimulus line %0d has the unknown unit code %0d", i, st_unit[i]);
                load_failed = 1'b1;
            end
        endcase
    endtask

    //////////////////////////////
    // Stimulus and final report
    initial begin
        rst       = 1'b1;
        alu_issue = 1'b0;
        alu_op    = '0;
        alu_id    = '0;
        alu_a     = '0;
        alu_b     = '0;
        mul_issue = 1'b0;
        mul_id    = '0;
        mul_a     = '0;
        mul_b     = '0;
        div_issue = 1'b0;
        div_rem   = 1'b0;
        div_id    = '0;
        div_a     = '0;
        div_b     = '0;
        exp_data  = '0;
        test_end  = 1'b0;
        test_num  = 0;
        seed      = 32'heada;
        skip_gap  = 1'b0;
        tests_expected = 1;
        read_stim();
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        // Reset test closes on the first edge out of reset
        repeat (2) @(negedge clk);
        test_num = 1;
        for (int i = 0; i < st_unit.size(); i++) begin
            run_line(i);
        end
        @(negedge clk);
        if (test_count != tests_expected) begin
            $display("Only %0d of %0d tests were reported", test_count, tests_expected);
            load_failed = 1'b1;
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors", test_count, fail_count,
                 err_count);
        if (err_count == 0 && fail_count == 0 && !load_failed) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog, sized from the number of stimulus lines
    initial begin
        wait (loaded);
        repeat (RST_CYCLES + 8 + st_unit.size() * (`DIV_STEPS + 8)) @(posedge clk);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* test/wb_stim.txt */
# unit op id a b expected, all hex
# unit 0 alu, 1 mul, 2 div (op 1 = remainder), 8 wait a cycles, 9 end of test
# ALU operations
0 0 1 00000005 00000003 00000008
0 1 2 00000005 00000007 fffffffe
0 2 3 f0f0f0f0 ff00ff00 f000f000
0 3 4 f0f0f0f0 0f0f0f0f ffffffff
0 4 5 aaaaaaaa ffff0000 5555aaaa
9 0 0 00000000 00000000 00000000
# Multiplier, first three back to back
1 0 1 00000007 00000006 0000002a
8 0 0 00000000 00000000 00000000
1 0 2 00010000 00010000 00000000
8 0 0 00000000 00000000 00000000
1 0 3 ffffffff 00000003 fffffffd
1 0 4 12345678 00000010 23456780
9 0 0 00000000 00000000 00000000
# Divider quotient and remainder, zero divisor included
2 0 1 00000064 00000007 0000000e
2 1 2 00000064 00000007 00000002
2 0 3 12345678 00000000 ffffffff
2 1 4 12345678 00000000 12345678
2 0 5 ffffffff 00000001 ffffffff
9 0 0 00000000 00000000 00000000
# Divider and multiplier finishing on the same edge
2 0 6 000003e8 0000000a 00000064
8 0 0 0000001e 00000000 00000000
1 0 7 00000003 00000005 0000000f
8 0 0 00000000 00000000 00000000
1 0 8 00000100 00000100 00010000
8 0 0 00000000 00000000 00000000
1 0 9 fffffffe fffffffe 00000004
0 0 a 00000001 00000001 00000002
9 0 0 00000000 00000000 00000000

/* sim.f */
+incdir+source
source/wb_types_pkg.sv
source/alu_unit.sv
source/mul_unit.sv
source/div_control.sv
source/div_counter.sv
source/div_datapath.sv
source/writeback.sv
source/wb_top.sv
test/wb_checker.sv
test/wb_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the writeback testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module wb_tb --Mdir obj_dir -o wb_sim

./obj_dir/wb_sim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
